//--- core_ldst_unit.f
+incdir+logic
logic/ldst_pkg.sv
logic/ldst_if.sv
logic/ldst_issue.sv
logic/ldst_router.sv
logic/ldst_load_align.sv
logic/core_ldst_unit.sv
dv/core_ldst_unit_tb.sv

//--- dv/core_ldst_unit_tb.sv
// Testbench for the load/store access unit
// Applies a table of loads and stores on the pipeline port, answers both
// buses with random back-pressure and fixed read data, and checks routing,
// IO rebasing, lane alignment and load return timing
`default_nettype none
`include "ldst_cfg.svh"

module core_ldst_unit_tb
	import ldst_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// Cycles allowed for any single wait
	localparam int TIMEOUT = 100;
	// Data memory word = word address xor this key
	localparam logic [31:0] MEM_KEY = 32'ha1b2_c3d4;

	typedef struct packed {
		logic                    iosr_ld;
		logic [`LDST_ADDR_W-1:0] iosr;
		logic                    rw;
		ldst_order_e             order;
		logic [`LDST_ADDR_W-1:0] addr;
		logic [`LDST_DATA_W-1:0] wdata;
		ldst_target_e            tgt;
		logic [`LDST_ADDR_W-1:0] bus_addr;
		logic [`LDST_DATA_W-1:0] rdata;
	} step_t;

	logic                        clock;
	logic                        rst;
	logic                        sysinfo_iosr_valid;
	logic [`LDST_ADDR_W-1:0]     sysinfo_iosr;
	logic                        ldst_req;
	logic                        ldst_busy;
	ldst_order_e                 ldst_order;
	logic                        ldst_rw;
	logic [`LDST_ADDR_W-1:0]     ldst_addr;
	logic [`LDST_DATA_W-1:0]     ldst_wdata;
	logic                        ldst_rvalid;
	logic [`LDST_DATA_W-1:0]     ldst_rdata;
	logic                        data_req;
	logic                        data_lock;
	ldst_order_e                 data_order;
	logic                        data_rw;
	logic [`LDST_ADDR_W-1:0]     data_addr;
	logic [`LDST_DATA_W-1:0]     data_wdata;
	logic                        data_valid;
	logic [`LDST_MEM_DATA_W-1:0] data_rdata;
	logic                        io_req;
	logic                        io_busy;
	ldst_order_e                 io_order;
	logic                        io_rw;
	logic [`LDST_ADDR_W-1:0]     io_addr;
	logic [`LDST_DATA_W-1:0]     io_wdata;
	logic                        io_valid;
	logic [`LDST_DATA_W-1:0]     io_rdata;

	// Stimulus table and names
	step_t steps[$];
	string step_name[$];

	integer seed = 6;
	int errors = 0;
	logic timed_out = 1'b0;
	// Pipeline accepts and predicted bus transfers
	int accepted = 0;
	int xfer_count = 0;
	int rvalid_count = 0;
	// Outstanding load, as seen on the bus
	logic load_open = 1'b0;
	string ld_name = "reset";
	logic [`LDST_DATA_W-1:0] ld_exp = '0;
	logic bus_valid_seen = 1'b0;
	// Responder state for the pending load answer
	logic resp_pending = 1'b0;
	int resp_delay = 0;
	ldst_target_e resp_tgt = TGT_DATA;
	logic [`LDST_ADDR_W-1:0] resp_addr = '0;

	core_ldst_unit dut_i (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
		end
	endtask

	// 64-bit line holding both words of the aligned 8-byte block
	function automatic logic [63:0] mem_line(input logic [31:0] addr);
		logic [31:0] base;
		base = {addr[31:3], 3'b000};
		return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
	endfunction

	task automatic add_row(input string name, input logic iosr_ld, input logic [31:0] iosr,
			input logic rw, input ldst_order_e order, input logic [31:0] addr,
			input logic [31:0] wdata, input ldst_target_e tgt,
			input logic [31:0] bus_addr, input logic [31:0] rdata);
		step_t s;
		s.iosr_ld  = iosr_ld;
		s.iosr     = iosr;
		s.rw       = rw;
		s.order    = order;
		s.addr     = addr;
		s.wdata    = wdata;
		s.tgt      = tgt;
		s.bus_addr = bus_addr;
		s.rdata    = rdata;
		steps.push_back(s);
		step_name.push_back(name);
	endtask

	task automatic build_table();
		// name, iosr load, iosr, rw (1 read), order, addr, wdata,
		// expected target, bus address, read data
		add_row("rst_st_word", 0, 0, 0, ORD_WORD, 'hf000_0010, 'h3344_5566, TGT_DATA,
			'hf000_0010, 0);
		add_row("rst_ld_top", 0, 0, 1, ORD_WORD, 'hffff_fff0, 0, TGT_DATA, 'hffff_fff0,
			'h5e4d_3c24);
		// Data memory lanes around 0x100
		add_row("dm_ld_b0", 0, 0, 1, ORD_BYTE, 'h100, 0, TGT_DATA, 'h100, 'hd4);
		add_row("dm_ld_b1", 0, 0, 1, ORD_BYTE, 'h101, 0, TGT_DATA, 'h101, 'hc2);
		add_row("dm_ld_b2", 0, 0, 1, ORD_BYTE, 'h102, 0, TGT_DATA, 'h102, 'hb2);
		add_row("dm_ld_b3", 0, 0, 1, ORD_BYTE, 'h103, 0, TGT_DATA, 'h103, 'ha1);
		add_row("dm_ld_b4", 0, 0, 1, ORD_BYTE, 'h104, 0, TGT_DATA, 'h104, 'hd0);
		add_row("dm_ld_h0", 0, 0, 1, ORD_HALF, 'h100, 0, TGT_DATA, 'h100, 'hc2d4);
		add_row("dm_ld_h2", 0, 0, 1, ORD_HALF, 'h102, 0, TGT_DATA, 'h102, 'ha1b2);
		add_row("dm_ld_h4", 0, 0, 1, ORD_HALF, 'h104, 0, TGT_DATA, 'h104, 'hc2d0);
		add_row("dm_ld_w0", 0, 0, 1, ORD_WORD, 'h100, 0, TGT_DATA, 'h100, 'ha1b2_c2d4);
		add_row("dm_ld_w4", 0, 0, 1, ORD_WORD, 'h104, 0, TGT_DATA, 'h104, 'ha1b2_c2d0);
		// IO window from 0x4000_0000
		add_row("io_st_word", 1, 'h4000_0000, 0, ORD_WORD, 'h7654_3210, 'hdead_beef, TGT_IO,
			'h3654_3210, 0);
		add_row("io_st_half", 0, 0, 0, ORD_HALF, 'h7654_3222, 'habcd, TGT_IO, 'h3654_3222, 0);
		add_row("io_ld_b0", 0, 0, 1, ORD_BYTE, 'h7654_3210, 0, TGT_IO, 'h3654_3210, 'hef);
		add_row("io_ld_b1", 0, 0, 1, ORD_BYTE, 'h7654_3211, 0, TGT_IO, 'h3654_3211, 'hcd);
		add_row("io_ld_b2", 0, 0, 1, ORD_BYTE, 'h7654_3212, 0, TGT_IO, 'h3654_3212, 'hab);
		add_row("io_ld_b3", 0, 0, 1, ORD_BYTE, 'h7654_3213, 0, TGT_IO, 'h3654_3213, 'hc9);
		add_row("io_ld_h0", 0, 0, 1, ORD_HALF, 'h7654_3210, 0, TGT_IO, 'h3654_3210, 'hcdef);
		add_row("io_ld_h2", 0, 0, 1, ORD_HALF, 'h7654_3216, 0, TGT_IO, 'h3654_3216, 'hc9ab);
		add_row("io_ld_w", 0, 0, 1, ORD_WORD, 'h7654_3214, 0, TGT_IO, 'h3654_3214,
			'hc9ab_cdeb);
		add_row("io_ld_start", 0, 0, 1, ORD_WORD, 'h4000_0000, 0, TGT_IO, 0, 'hffff_ffff);
		add_row("dm_ld_below", 0, 0, 1, ORD_WORD, 'h3fff_fffc, 0, TGT_DATA, 'h3fff_fffc,
			'h9e4d_3c28);
		add_row("dm_st_below", 0, 0, 0, ORD_HALF, 'h202, 'h1234, TGT_DATA, 'h202, 0);
		// IO window moved down to 0x8000
		add_row("io2_ld_b1", 1, 'h8000, 1, ORD_BYTE, 'h9a01, 0, TGT_IO, 'h1a01, 'he5);
		add_row("dm2_ld_b1", 0, 0, 1, ORD_BYTE, 'h7ffd, 0, TGT_DATA, 'h7ffd, 'hbc);
		add_row("io2_st_byte", 0, 0, 0, ORD_BYTE, 'h1_0000, 'ha5, TGT_IO, 'h8000, 0);
	endtask

	// Bus responders: random lock and busy, one load answer after 0 to 3 cycles
	initial begin
		forever begin
			@(posedge clock);
			#1;
			data_lock  = ($random(seed) & 3) == 0;
			io_busy    = ($random(seed) & 3) == 0;
			data_valid = 1'b0;
			io_valid   = 1'b0;
			if (resp_pending) begin
				if (resp_delay == 0) begin
					resp_pending = 1'b0;
					if (resp_tgt == TGT_IO) begin
						io_valid = 1'b1;
						// IO read data is the inverted rebased address
						io_rdata = ~resp_addr;
					end else begin
						data_valid = 1'b1;
						data_rdata = mem_line(resp_addr);
					end
				end else begin
					resp_delay = resp_delay - 1;
				end
			end
		end
	end

	// Monitor on the falling edge, where all DUT outputs are settled
	initial begin
		step_t s;
		string nm;
		ldst_target_e got_tgt;
		logic [31:0] got_addr;
		forever begin
			@(negedge clock);
			if (rst) begin
				check_val("reset data_req", 0, data_req);
				check_val("reset io_req", 0, io_req);
				check_val("reset ldst_busy", 0, ldst_busy);
				check_val("reset ldst_rvalid", 0, ldst_rvalid);
			end
			// rvalid exactly one cycle after a bus valid, never otherwise
			check_val({ld_name, " rvalid"}, bus_valid_seen, ldst_rvalid);
			if (ldst_rvalid) begin
				rvalid_count++;
				load_open = 1'b0;
				check_val({ld_name, " rdata"}, ld_exp, ldst_rdata);
			end
			bus_valid_seen = data_valid || io_valid;
			check_val("one bus at a time", 0, data_req && io_req);
			// Transfer at the coming rising edge
			if ((data_req && !data_lock) || (io_req && !io_busy)) begin
				if (xfer_count >= steps.size()) begin
					errors++;
					$display("Bus transfer at %0t with no table request left", $time);
				end else begin
					s  = steps[xfer_count];
					nm = step_name[xfer_count];
					got_tgt  = (io_req && !io_busy) ? TGT_IO : TGT_DATA;
					got_addr = (got_tgt == TGT_IO) ? io_addr : data_addr;
					check_val({nm, " target"}, s.tgt, got_tgt);
					check_val({nm, " bus addr"}, s.bus_addr, got_addr);
					check_val({nm, " order"}, s.order,
						(got_tgt == TGT_IO) ? io_order : data_order);
					check_val({nm, " rw"}, s.rw, (got_tgt == TGT_IO) ? io_rw : data_rw);
					check_val({nm, " wdata"}, s.wdata,
						(got_tgt == TGT_IO) ? io_wdata : data_wdata);
					if (s.rw) begin
						load_open    = 1'b1;
						ld_name      = nm;
						ld_exp       = s.rdata;
						resp_pending = 1'b1;
						resp_delay   = $random(seed) & 3;
						resp_tgt     = got_tgt;
						resp_addr    = got_addr;
					end
				end
				xfer_count++;
			end
		end
	end

	task automatic wait_accept();
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clock);
			if (!ldst_busy) begin
				accepted++;
				return;
			end
		end
		$display("Timeout: ldst_busy never released the pipeline request");
		timed_out = 1'b1;
	endtask

	task automatic wait_drained();
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			@(negedge clock);
			// Let the monitor update first
			#1;
			if (xfer_count == accepted && !load_open) begin
				return;
			end
		end
		$display("Timeout: accepted requests did not reach a bus or a load never returned");
		timed_out = 1'b1;
	endtask

	initial begin
		int i;
		int loads;
		rst                = 1'b1;
		sysinfo_iosr_valid = 1'b0;
		sysinfo_iosr       = '0;
		ldst_req           = 1'b0;
		ldst_order         = ORD_WORD;
		ldst_rw            = 1'b0;
		ldst_addr          = '0;
		ldst_wdata         = '0;
		data_lock          = 1'b0;
		data_valid         = 1'b0;
		data_rdata         = '0;
		io_busy            = 1'b0;
		io_valid           = 1'b0;
		io_rdata           = '0;
		build_table();
		loads = 0;
		foreach (steps[k]) begin
			if (steps[k].rw) begin
				loads++;
			end
		end
		repeat (3) @(posedge clock);
		#1;
		rst = 1'b0;
		for (i = 0; i < steps.size() && !timed_out; i++) begin
			@(posedge clock);
			#1;
			if (steps[i].iosr_ld) begin
				// Empty the unit so the new window applies only to later rows
				ldst_req = 1'b0;
				wait_drained();
				@(posedge clock);
				#1;
				sysinfo_iosr_valid = 1'b1;
				sysinfo_iosr       = steps[i].iosr;
				@(posedge clock);
				#1;
				sysinfo_iosr_valid = 1'b0;
			end
			ldst_req   = 1'b1;
			ldst_rw    = steps[i].rw;
			ldst_order = steps[i].order;
			ldst_addr  = steps[i].addr;
			ldst_wdata = steps[i].wdata;
			wait_accept();
		end
		@(posedge clock);
		#1;
		ldst_req = 1'b0;
		if (!timed_out) begin
			wait_drained();
		end
		// Idle cycles to catch a stray bus request or rvalid
		repeat (4) @(posedge clock);
		check_val("bus transfer count", steps.size(), xfer_count);
		check_val("load return count", loads, rvalid_count);
		$display("Error counts: %0d check errors, %0d timeouts", errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/core_ldst_unit.sv
// Load/store access unit, top level
// Sits between the core pipeline and the data memory and IO buses
// Pipeline requests transfer on ldst_req && !ldst_busy, loads come back
// on ldst_rvalid; IOSR sets where the IO address window starts
`default_nettype none
`include "ldst_cfg.svh"

module core_ldst_unit
	import ldst_pkg::*;
(
	input  logic                        clock,
	input  logic                        rst,
	// System information
	input  logic                        sysinfo_iosr_valid,
	input  logic [`LDST_ADDR_W-1:0]     sysinfo_iosr,
	// Pipeline load/store port
	input  logic                        ldst_req,
	output logic                        ldst_busy,
	input  ldst_order_e                 ldst_order,
	// High for a read
	input  logic                        ldst_rw,
	input  logic [`LDST_ADDR_W-1:0]     ldst_addr,
	input  logic [`LDST_DATA_W-1:0]     ldst_wdata,
	output logic                        ldst_rvalid,
	output logic [`LDST_DATA_W-1:0]     ldst_rdata,
	// Data memory bus
	output logic                        data_req,
	input  logic                        data_lock,
	output ldst_order_e                 data_order,
	output logic                        data_rw,
	output logic [`LDST_ADDR_W-1:0]     data_addr,
	output logic [`LDST_DATA_W-1:0]     data_wdata,
	input  logic                        data_valid,
	input  logic [`LDST_MEM_DATA_W-1:0] data_rdata,
	// IO bus, rebased addresses
	output logic                        io_req,
	input  logic                        io_busy,
	output ldst_order_e                 io_order,
	output logic                        io_rw,
	output logic [`LDST_ADDR_W-1:0]     io_addr,
	output logic [`LDST_DATA_W-1:0]     io_wdata,
	input  logic                        io_valid,
	input  logic [`LDST_DATA_W-1:0]     io_rdata
);

	// Held request, issue to router
	ldst_req_if req_link ();
	// Raw load return, router to aligner
	ldst_ret_if ret_link ();

	ldst_issue u_issue (
		.clock     (clock),
		.rst       (rst),
		.cpu_req   (ldst_req),
		.cpu_busy  (ldst_busy),
		.cpu_order (ldst_order),
		.cpu_rw    (ldst_rw),
		.cpu_addr  (ldst_addr),
		.cpu_wdata (ldst_wdata),
		.req       (req_link.issuer)
	);

	ldst_router u_router (
		.clock      (clock),
		.rst        (rst),
		.iosr_valid (sysinfo_iosr_valid),
		.iosr       (sysinfo_iosr),
		.req        (req_link.router),
		.ret        (ret_link.router),
		.data_req   (data_req),
		.data_lock  (data_lock),
		.data_order (data_order),
		.data_rw    (data_rw),
		.data_addr  (data_addr),
		.data_wdata (data_wdata),
		.data_valid (data_valid),
		.data_rdata (data_rdata),
		.io_req     (io_req),
		.io_busy    (io_busy),
		.io_order   (io_order),
		.io_rw      (io_rw),
		.io_addr    (io_addr),
		.io_wdata   (io_wdata),
		.io_valid   (io_valid),
		.io_rdata   (io_rdata)
	);

	ldst_load_align u_align (
		.clock  (clock),
		.rst    (rst),
		.ret    (ret_link.aligner),
		.rvalid (ldst_rvalid),
		.rdata  (ldst_rdata)
	);

endmodule

`default_nettype wire

//--- logic/ldst_cfg.svh
// Width and reset constants for the load/store access unit
// Include in any RTL file that sizes addresses, data or bus read data
`ifndef LDST_CFG_SVH
`define LDST_CFG_SVH

// Pipeline address width
`define LDST_ADDR_W 32

// Pipeline store data and IO read data width
`define LDST_DATA_W 32

// Data memory returns a full 64-bit line
`define LDST_MEM_DATA_W 64

// IO start address before the first IOSR load
// All ones keeps every access on data memory
`define LDST_IO_START_RST 32'hffff_ffff

`endif

//--- logic/ldst_if.sv
// Internal links of the load/store access unit
// ldst_req_if carries one held request from the issue stage to the router
// ldst_ret_if carries raw load return data from the router to the aligner
`default_nettype none
`include "ldst_cfg.svh"

interface ldst_req_if
	import ldst_pkg::*;
();
	// Request handshake, transfer on req && !busy
	logic                    req;
	logic                    busy;
	// Request fields, stable while req && busy
	ldst_order_e             order;
	// High for a read
	logic                    rw;
	logic [`LDST_ADDR_W-1:0] addr;
	logic [`LDST_DATA_W-1:0] wdata;

	modport issuer (
		output req,
		output order,
		output rw,
		output addr,
		output wdata,
		input  busy
	);

	modport router (
		input  req,
		input  order,
		input  rw,
		input  addr,
		input  wdata,
		output busy
	);
endinterface

interface ldst_ret_if
	import ldst_pkg::*;
();
	// One-cycle pulse, no back-pressure
	logic                        valid;
	ldst_target_e                target;
	ldst_order_e                 order;
	// Bus address bits 2 to 0 of the load
	logic [2:0]                  lane;
	// IO data sits in the low half
	logic [`LDST_MEM_DATA_W-1:0] data;

	modport router (
		output valid,
		output target,
		output order,
		output lane,
		output data
	);

	modport aligner (
		input  valid,
		input  target,
		input  order,
		input  lane,
		input  data
	);
endinterface

`default_nettype wire

//--- logic/ldst_issue.sv
// Input stage of the load/store access unit
// Takes pipeline requests into a one-entry holding register and presents
// the held entry to the router; the pipeline sees busy only while full
`default_nettype none
`include "ldst_cfg.svh"

module ldst_issue
	import ldst_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	// Pipeline side
	input  logic                    cpu_req,
	output logic                    cpu_busy,
	input  ldst_order_e             cpu_order,
	input  logic                    cpu_rw,
	input  logic [`LDST_ADDR_W-1:0] cpu_addr,
	input  logic [`LDST_DATA_W-1:0] cpu_wdata,
	// Toward the router
	ldst_req_if.issuer              req
);

	// Entry holds a request not yet taken by the router
	logic full;
	logic accept;

	// Busy only when the entry cannot drain this cycle
	assign cpu_busy = full && req.busy;
	assign accept   = cpu_req && !cpu_busy;

	assign req.req = full;

	// Full flag
	// Refill on the drain edge keeps it set
	always_ff @(posedge clock) begin
		if (rst) begin
			full <= 1'b0;
		end else if (accept) begin
			full <= 1'b1;
		end else if (full && !req.busy) begin
			full <= 1'b0;
		end
	end

	// Payload of the held entry
	always_ff @(posedge clock) begin
		if (accept) begin
			req.order <= cpu_order;
			req.rw    <= cpu_rw;
			req.addr  <= cpu_addr;
			req.wdata <= cpu_wdata;
		end
	end

	// No size-less access from the pipeline
	a_no_ord_none: assert property (
		@(posedge clock) disable iff (rst)
		accept |-> cpu_order != ORD_NONE
	);

endmodule

`default_nettype wire

//--- logic/ldst_load_align.sv
// Output stage of the load/store access unit
// Picks the 32-bit word from the return bus, cuts out the byte or halfword
// lane, zero-extends it and registers the load result for the pipeline
`default_nettype none
`include "ldst_cfg.svh"

module ldst_load_align
	import ldst_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	// Raw return from the router
	ldst_ret_if.aligner             ret,
	// Pipeline load result
	output logic                    rvalid,
	output logic [`LDST_DATA_W-1:0] rdata
);

	logic [`LDST_DATA_W-1:0] word;
	logic [`LDST_DATA_W-1:0] lane_data;

	// Word select
	// Data memory line carries two words, IO only the low one
	always_comb begin
		if (ret.target == TGT_DATA && ret.lane[2]) begin
			word = ret.data[`LDST_MEM_DATA_W-1:`LDST_DATA_W];
		end else begin
			word = ret.data[`LDST_DATA_W-1:0];
		end
	end

	// Lane extract, zero-extended
	always_comb begin
		lane_data = '0;
		case (ret.order)
			ORD_BYTE: begin
				// Byte at lane bits 1 to 0
				lane_data[7:0] = word[{ret.lane[1:0], 3'b000} +: 8];
			end
			ORD_HALF: begin
				// Halfword at lane bit 1
				lane_data[15:0] = word[{ret.lane[1], 4'b0000} +: 16];
			end
			default: begin
				lane_data = word;
			end
		endcase
	end

	// Result valid, one cycle after the bus valid
	always_ff @(posedge clock) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else begin
			rvalid <= ret.valid;
		end
	end

	// Result data
	always_ff @(posedge clock) begin
		if (ret.valid) begin
			rdata <= lane_data;
		end
	end

endmodule

`default_nettype wire

//--- logic/ldst_pkg.sv
// Shared types of the load/store access unit
// Modules and interfaces take these by a wildcard import
`default_nettype none

package ldst_pkg;

	// Access size, same coding as the core's bus order field
	typedef enum logic [1:0] {
		ORD_BYTE = 2'b00,
		ORD_HALF = 2'b01,
		ORD_WORD = 2'b10,
		// Illegal on a request
		ORD_NONE = 2'b11
	} ldst_order_e;

	// Bus that serves an access
	typedef enum logic {
		TGT_DATA = 1'b0,
		TGT_IO   = 1'b1
	} ldst_target_e;

	// Router FSM
	typedef enum logic [1:0] {
		ST_IDLE      = 2'b00,
		// Bus request held off by lock
		ST_ISSUE     = 2'b01,
		// Load sent, waiting for the bus valid
		ST_WAIT_LOAD = 2'b10
	} ldst_state_e;

endpackage

`default_nettype wire

//--- logic/ldst_router.sv
// Routing stage of the load/store access unit
// Holds the IO start address, sends each held request to data memory or IO,
// rebases IO addresses and tracks the single outstanding load
// Load return data goes out raw on the return interface for alignment
`default_nettype none
`include "ldst_cfg.svh"

module ldst_router
	import ldst_pkg::*;
(
	input  logic                        clock,
	input  logic                        rst,
	// System information, IO start address
	input  logic                        iosr_valid,
	input  logic [`LDST_ADDR_W-1:0]     iosr,
	// Internal links
	ldst_req_if.router                  req,
	ldst_ret_if.router                  ret,
	// Data memory bus
	output logic                        data_req,
	input  logic                        data_lock,
	output ldst_order_e                 data_order,
	output logic                        data_rw,
	output logic [`LDST_ADDR_W-1:0]     data_addr,
	output logic [`LDST_DATA_W-1:0]     data_wdata,
	input  logic                        data_valid,
	input  logic [`LDST_MEM_DATA_W-1:0] data_rdata,
	// IO bus
	output logic                        io_req,
	input  logic                        io_busy,
	output ldst_order_e                 io_order,
	output logic                        io_rw,
	output logic [`LDST_ADDR_W-1:0]     io_addr,
	output logic [`LDST_DATA_W-1:0]     io_wdata,
	input  logic                        io_valid,
	input  logic [`LDST_DATA_W-1:0]     io_rdata
);

	ldst_state_e             state;
	logic [`LDST_ADDR_W-1:0] iosr_q;
	// Target and bus address of a request held by lock
	ldst_target_e            pend_tgt;
	logic [`LDST_ADDR_W-1:0] pend_addr;
	// Outstanding load
	ldst_target_e            ld_tgt;
	ldst_order_e             ld_order;
	logic [2:0]              ld_lane;
	// Current decode
	ldst_target_e            sel_tgt;
	logic [`LDST_ADDR_W-1:0] sel_addr;
	logic                    bus_active;
	logic                    sel_lock;
	logic                    sel_valid;
	logic                    xfer;

	// IO start address register
	always_ff @(posedge clock) begin
		if (rst) begin
			iosr_q <= `LDST_IO_START_RST;
		end else if (iosr_valid) begin
			iosr_q <= iosr;
		end
	end

	// Target decode
	// A request under lock keeps the decision of its first cycle,
	// so an IOSR load cannot move it to the other bus
	always_comb begin
		if (state == ST_ISSUE) begin
			sel_tgt  = pend_tgt;
			sel_addr = pend_addr;
		end else if (req.addr >= iosr_q) begin
			sel_tgt  = TGT_IO;
			sel_addr = req.addr - iosr_q;
		end else begin
			sel_tgt  = TGT_DATA;
			sel_addr = req.addr;
		end
	end

	// No new bus request while a load is out
	assign bus_active = req.req && (state != ST_WAIT_LOAD);
	assign sel_lock   = (sel_tgt == TGT_IO) ? io_busy : data_lock;
	assign xfer       = bus_active && !sel_lock;
	assign sel_valid  = (ld_tgt == TGT_IO) ? io_valid : data_valid;

	// Busy covers bus back-pressure and the whole load wait
	assign req.busy = (state == ST_WAIT_LOAD) || (bus_active && sel_lock);

	// Data memory side, address unchanged
	assign data_req   = bus_active && (sel_tgt == TGT_DATA);
	assign data_order = req.order;
	assign data_rw    = req.rw;
	assign data_addr  = sel_addr;
	assign data_wdata = req.wdata;

	// IO side, rebased address
	assign io_req   = bus_active && (sel_tgt == TGT_IO);
	assign io_order = req.order;
	assign io_rw    = req.rw;
	assign io_addr  = sel_addr;
	assign io_wdata = req.wdata;

	// Raw return, pulse on the bus valid edge
	assign ret.valid  = (state == ST_WAIT_LOAD) && sel_valid;
	assign ret.target = ld_tgt;
	assign ret.order  = ld_order;
	assign ret.lane   = ld_lane;
	assign ret.data   = (ld_tgt == TGT_IO) ?
		{{(`LDST_MEM_DATA_W - `LDST_DATA_W){1'b0}}, io_rdata} : data_rdata;

	// Router FSM
	always_ff @(posedge clock) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE, ST_ISSUE: begin
					if (xfer) begin
						// Stores finish here
						state <= req.rw ? ST_WAIT_LOAD : ST_IDLE;
					end else if (bus_active) begin
						state <= ST_ISSUE;
					end
				end
				ST_WAIT_LOAD: begin
					if (sel_valid) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Decision capture on a locked first cycle, load context on transfer
	always_ff @(posedge clock) begin
		if (state == ST_IDLE && bus_active) begin
			pend_tgt  <= sel_tgt;
			pend_addr <= sel_addr;
		end
		if (xfer) begin
			ld_tgt   <= sel_tgt;
			ld_order <= req.order;
			ld_lane  <= sel_addr[2:0];
		end
	end

	a_one_bus: assert property (
		@(posedge clock) disable iff (rst)
		!(data_req && io_req)
	);

	// Valid only from the bus that owns the outstanding load
	a_data_valid_owned: assert property (
		@(posedge clock) disable iff (rst)
		data_valid |-> state == ST_WAIT_LOAD && ld_tgt == TGT_DATA
	);

	a_io_valid_owned: assert property (
		@(posedge clock) disable iff (rst)
		io_valid |-> state == ST_WAIT_LOAD && ld_tgt == TGT_IO
	);

endmodule

`default_nettype wire
